// File: design/rv_core_pkg.sv
package rv_core_pkg;

   // --------------------
   // widths and base types
   // --------------------
   localparam int xlen = 32;

   typedef logic [xlen-1:0] word_t;
   typedef logic [xlen-3:0] pc_t;       // word address, byte address is {pc, 2'b00}
   typedef logic [4:0]      reg_addr_t;
   typedef logic [3:0]      byte_en_t;  // one bit per lane, all zero = no write

   localparam pc_t pc_reset = '0;       // start of program

   // --------------------
   // major opcodes
   // --------------------
   typedef enum logic [6:0] {
      op_load     = 7'b0000011,
      op_misc_mem = 7'b0001111,         // fence
      op_imm      = 7'b0010011,
      op_auipc    = 7'b0010111,
      op_store    = 7'b0100011,
      op_reg      = 7'b0110011,
      op_lui      = 7'b0110111,
      op_branch   = 7'b1100011,
      op_jalr     = 7'b1100111,
      op_jal      = 7'b1101111,
      op_system   = 7'b1110011
   } opcode_e;

   // alu funct3
   localparam logic [2:0] f3_add  = 3'b000;  // add, sub with alt
   localparam logic [2:0] f3_sll  = 3'b001;
   localparam logic [2:0] f3_slt  = 3'b010;
   localparam logic [2:0] f3_sltu = 3'b011;
   localparam logic [2:0] f3_xor  = 3'b100;
   localparam logic [2:0] f3_sr   = 3'b101;  // srl, sra with alt
   localparam logic [2:0] f3_or   = 3'b110;
   localparam logic [2:0] f3_and  = 3'b111;

   // branch funct3
   localparam logic [2:0] f3_beq  = 3'b000;
   localparam logic [2:0] f3_bne  = 3'b001;
   localparam logic [2:0] f3_blt  = 3'b100;
   localparam logic [2:0] f3_bge  = 3'b101;
   localparam logic [2:0] f3_bltu = 3'b110;
   localparam logic [2:0] f3_bgeu = 3'b111;

   // load funct3
   localparam logic [2:0] f3_lb   = 3'b000;
   localparam logic [2:0] f3_lh   = 3'b001;
   localparam logic [2:0] f3_lw   = 3'b010;
   localparam logic [2:0] f3_lbu  = 3'b100;
   localparam logic [2:0] f3_lhu  = 3'b101;

   // store funct3
   localparam logic [2:0] f3_sb   = 3'b000;
   localparam logic [2:0] f3_sh   = 3'b001;
   localparam logic [2:0] f3_sw   = 3'b010;

   // --------------------
   // decoded instruction
   // --------------------
   typedef struct packed {
      logic alu_reg;
      logic alu_imm;
      logic lui;
      logic auipc;
      logic jal;
      logic jalr;
      logic branch;
      logic load;
      logic store;
      logic halt;                       // system, fence, anything unknown
   } dec_class_t;                       // exactly one bit set

   typedef struct packed {
      dec_class_t cls;
      reg_addr_t  rd;
      reg_addr_t  rs1;
      reg_addr_t  rs2;
      logic [2:0] funct3;
      logic       alt;                  // funct7[5], reg ops and imm right shifts only
      word_t      imm;                  // sign-extended for the format
   } dec_t;

   // --------------------
   // data memory request
   // --------------------
   typedef struct packed {
      logic       strobe;
      byte_en_t   be;                   // zero with strobe high = load
      pc_t        addr;                 // word address
      word_t      wdat;                 // lanes already replicated
   } dmem_req_t;

endpackage

// File: design/rv_decoder.sv
`timescale 1ns/10ps

module rv_decoder (
   input  rv_core_pkg::word_t instr,
   output rv_core_pkg::dec_t  dec
);

   rv_core_pkg::word_t imm_i, imm_s, imm_b, imm_u, imm_j;

   // --------------------
   // immediates per format
   // --------------------
   always_comb begin
      imm_i = {{20{instr[31]}}, instr[31:20]};
      imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
      imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
      imm_u = {instr[31:12], 12'd0};                // low 12 bits zero
      imm_j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
   end

   // --------------------
   // opcode class and fields
   // --------------------
   always_comb begin
      dec        = '0;
      dec.rd     = instr[11:7];
      dec.rs1    = instr[19:15];
      dec.rs2    = instr[24:20];
      dec.funct3 = instr[14:12];

      case (instr[6:0])
         rv_core_pkg::op_reg    : dec.cls.alu_reg = 1'b1;
         rv_core_pkg::op_imm    : dec.cls.alu_imm = 1'b1;
         rv_core_pkg::op_lui    : dec.cls.lui     = 1'b1;
         rv_core_pkg::op_auipc  : dec.cls.auipc   = 1'b1;
         rv_core_pkg::op_jal    : dec.cls.jal     = 1'b1;
         rv_core_pkg::op_jalr   : dec.cls.jalr    = 1'b1;
         rv_core_pkg::op_branch : dec.cls.branch  = 1'b1;
         rv_core_pkg::op_load   : dec.cls.load    = 1'b1;
         rv_core_pkg::op_store  : dec.cls.store   = 1'b1;
         rv_core_pkg::op_misc_mem,
         rv_core_pkg::op_system : dec.cls.halt    = 1'b1;  // core parks here
         default                : dec.cls.halt    = 1'b1;  // unknown opcode too
      endcase

      // sub/sra select, ignored for everything else
      dec.alt = instr[30] & (dec.cls.alu_reg |
                             (dec.cls.alu_imm & (dec.funct3 == rv_core_pkg::f3_sr)));

      // pick the immediate for this format
      if (dec.cls.alu_imm | dec.cls.jalr | dec.cls.load) begin
         dec.imm = imm_i;
      end
      else if (dec.cls.store) begin
         dec.imm = imm_s;
      end
      else if (dec.cls.branch) begin
         dec.imm = imm_b;
      end
      else if (dec.cls.lui | dec.cls.auipc) begin
         dec.imm = imm_u;
      end
      else if (dec.cls.jal) begin
         dec.imm = imm_j;
      end
      else begin
         dec.imm = '0;                              // reg ops, halt
      end
   end

endmodule

// File: design/rv_regfile.sv
`timescale 1ns/10ps

module rv_regfile (
   input  logic                   clk,
   input  rv_core_pkg::reg_addr_t rs1_addr,
   input  rv_core_pkg::reg_addr_t rs2_addr,
   input  rv_core_pkg::reg_addr_t rd_addr,
   input  logic                   we,
   input  rv_core_pkg::word_t     wdat,
   output rv_core_pkg::word_t     rs1_dat,
   output rv_core_pkg::word_t     rs2_dat
);

   // x1..x31, x0 has no storage
   rv_core_pkg::word_t regs [31:1];

   always_ff @(posedge clk) begin
      if (we && (rd_addr != '0)) begin    // writes to x0 dropped
         regs[rd_addr] <= wdat;
      end
   end

   // combinational reads, x0 reads zero
   always_comb begin
      rs1_dat = (rs1_addr == '0) ? '0 : regs[rs1_addr];
      rs2_dat = (rs2_addr == '0) ? '0 : regs[rs2_addr];
   end

endmodule

// File: design/rv_alu.sv
`timescale 1ns/10ps

module rv_alu (
   input  rv_core_pkg::dec_t  dec,
   input  rv_core_pkg::word_t rs1_dat,
   input  rv_core_pkg::word_t rs2_dat,
   output rv_core_pkg::word_t result,
   output logic               branch_taken
);

   rv_core_pkg::word_t op2;
   logic [4:0]         shamt;
   logic               eq, lt, ltu;
   logic               cond;

   // --------------------
   // operands and compares
   // --------------------
   always_comb begin
      op2   = (dec.cls.alu_reg | dec.cls.branch) ? rs2_dat : dec.imm;
      shamt = op2[4:0];                             // imm[4:0] or rs2[4:0]
      eq    = (rs1_dat == op2);
      lt    = ($signed(rs1_dat) < $signed(op2));
      ltu   = (rs1_dat < op2);
   end

   // --------------------
   // result
   // --------------------
   always_comb begin
      case (dec.funct3)
         rv_core_pkg::f3_add  : result = (dec.cls.alu_reg & dec.alt) ?
                                         rs1_dat - op2 : rs1_dat + op2;  // jalr lands here
         rv_core_pkg::f3_sll  : result = rs1_dat << shamt;
         rv_core_pkg::f3_slt  : result = {31'd0, lt};
         rv_core_pkg::f3_sltu : result = {31'd0, ltu};
         rv_core_pkg::f3_xor  : result = rs1_dat ^ op2;
         rv_core_pkg::f3_sr   : result = dec.alt ? rv_core_pkg::word_t'($signed(rs1_dat) >>> shamt)
                                                 : rs1_dat >> shamt;
         rv_core_pkg::f3_or   : result = rs1_dat | op2;
         default              : result = rs1_dat & op2;  // f3_and
      endcase
   end

   // --------------------
   // branch decision
   // --------------------
   always_comb begin
      case (dec.funct3)
         rv_core_pkg::f3_beq  : cond = eq;
         rv_core_pkg::f3_bne  : cond = !eq;
         rv_core_pkg::f3_blt  : cond = lt;
         rv_core_pkg::f3_bge  : cond = !lt;
         rv_core_pkg::f3_bltu : cond = ltu;
         rv_core_pkg::f3_bgeu : cond = !ltu;
         default              : cond = 1'b0;  // 010/011 not a branch
      endcase
      branch_taken = dec.cls.branch & cond;
   end

endmodule

// File: design/rv_lsu.sv
`timescale 1ns/10ps

module rv_lsu (
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic                   start,      // ls instr in execute
   input  logic                   finish,     // last cycle of the access
   input  rv_core_pkg::dec_t      dec,
   input  rv_core_pkg::word_t     rs1_dat,
   input  rv_core_pkg::word_t     rs2_dat,
   output rv_core_pkg::dmem_req_t dmem_req,
   input  rv_core_pkg::word_t     dmem_rdat,
   output rv_core_pkg::word_t     load_data
);

   rv_core_pkg::word_t    addr, wdat_next, rdat_shift;
   rv_core_pkg::byte_en_t be_next;

   logic                  req_strobe;
   rv_core_pkg::byte_en_t req_be;
   rv_core_pkg::pc_t      req_addr;
   rv_core_pkg::word_t    req_wdat;
   logic [2:0]            ld_funct3;  // kept for extraction in mem
   logic [1:0]            ld_off;     // byte offset in word
   logic [15:0]           ld_half;

   // --------------------
   // request forming
   // --------------------
   always_comb begin
      addr      = rs1_dat + dec.imm;
      be_next   = '0;                 // loads: no lanes
      wdat_next = rs2_dat;
      if (dec.cls.store) begin
         case (dec.funct3)
            rv_core_pkg::f3_sb : begin
               be_next   = rv_core_pkg::byte_en_t'(4'b0001 << addr[1:0]);
               wdat_next = {4{rs2_dat[7:0]}};
            end
            rv_core_pkg::f3_sh : begin
               be_next   = addr[1] ? 4'b1100 : 4'b0011;
               wdat_next = {2{rs2_dat[15:0]}};
            end
            rv_core_pkg::f3_sw : be_next = 4'b1111;
            default            : be_next = '0;
         endcase
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         req_strobe <= 1'b0;
         req_be     <= '0;
      end
      else if (finish) begin          // drop at end of access
         req_strobe <= 1'b0;
         req_be     <= '0;
      end
      else if (start) begin
         req_strobe <= 1'b1;          // start only comes with a load or store
         req_be     <= be_next;
      end
   end

   // payload, only meaningful with strobe
   always_ff @(posedge clk) begin
      if (start) begin
         req_addr  <= addr[31:2];
         req_wdat  <= wdat_next;
         ld_funct3 <= dec.funct3;
         ld_off    <= addr[1:0];
      end
   end

   assign dmem_req = '{strobe: req_strobe, be: req_be, addr: req_addr, wdat: req_wdat};

   // --------------------
   // load extraction
   // --------------------
   always_comb begin
      rdat_shift = dmem_rdat >> {ld_off, 3'b000};    // addressed byte to lane 0
      ld_half    = ld_off[1] ? dmem_rdat[31:16] : dmem_rdat[15:0];
      case (ld_funct3)
         rv_core_pkg::f3_lb  : load_data = {{24{rdat_shift[7]}}, rdat_shift[7:0]};
         rv_core_pkg::f3_lh  : load_data = {{16{ld_half[15]}}, ld_half};
         rv_core_pkg::f3_lbu : load_data = {24'd0, rdat_shift[7:0]};
         rv_core_pkg::f3_lhu : load_data = {16'd0, ld_half};
         default             : load_data = dmem_rdat;  // f3_lw
      endcase
   end

endmodule

// File: design/rv_core.sv
`timescale 1ns/10ps

module rv_core (
   input  logic                   clk,
   input  logic                   rst_n,
   output rv_core_pkg::pc_t       imem_addr,
   input  rv_core_pkg::word_t     imem_rdat,
   output rv_core_pkg::dmem_req_t dmem_req,
   input  rv_core_pkg::word_t     dmem_rdat,
   input  logic                   dmem_rdy,
   output logic                   halted
);

   typedef enum logic [1:0] {
      st_execute = 2'd0,
      st_mem     = 2'd1,            // load/store access in progress
      st_halt    = 2'd2
   } state_e;

   state_e             state;
   rv_core_pkg::pc_t   pc, pc_inc, pc_imm, next_pc;
   rv_core_pkg::dec_t  dec;
   rv_core_pkg::word_t rs1_dat, rs2_dat, alu_result, load_data, rf_wdat;
   logic               branch_taken, rf_we;
   logic               is_ls, lsu_start, lsu_finish;

   // --------------------
   // fetch and decode
   // --------------------
   assign imem_addr = pc;           // held through mem, so dec stays valid

   rv_decoder u_decoder (
      .instr (imem_rdat),
      .dec   (dec)
   );

   rv_regfile u_regfile (
      .clk      (clk),
      .rs1_addr (dec.rs1),
      .rs2_addr (dec.rs2),
      .rd_addr  (dec.rd),
      .we       (rf_we),
      .wdat     (rf_wdat),
      .rs1_dat  (rs1_dat),
      .rs2_dat  (rs2_dat)
   );

   rv_alu u_alu (
      .dec          (dec),
      .rs1_dat      (rs1_dat),
      .rs2_dat      (rs2_dat),
      .result       (alu_result),
      .branch_taken (branch_taken)
   );

   rv_lsu u_lsu (
      .clk       (clk),
      .rst_n     (rst_n),
      .start     (lsu_start),
      .finish    (lsu_finish),
      .dec       (dec),
      .rs1_dat   (rs1_dat),
      .rs2_dat   (rs2_dat),
      .dmem_req  (dmem_req),
      .dmem_rdat (dmem_rdat),
      .load_data (load_data)
   );

   // --------------------
   // next pc and write-back
   // --------------------
   always_comb begin
      is_ls      = dec.cls.load | dec.cls.store;
      lsu_start  = (state == st_execute) & is_ls;
      lsu_finish = (state == st_mem) & (dec.cls.store | dmem_rdy);  // stores never wait

      pc_inc = pc + 30'd1;
      pc_imm = pc + dec.imm[31:2];  // jal and branch targets
      if (dec.cls.jal | branch_taken) begin
         next_pc = pc_imm;
      end
      else if (dec.cls.jalr) begin
         next_pc = alu_result[31:2];
      end
      else begin
         next_pc = pc_inc;
      end

      if (dec.cls.jal | dec.cls.jalr) begin
         rf_wdat = {pc_inc, 2'b00};                  // return address
      end
      else if (dec.cls.auipc) begin
         rf_wdat = {pc, 2'b00} + dec.imm;
      end
      else if (dec.cls.lui) begin
         rf_wdat = dec.imm;
      end
      else if (dec.cls.load) begin
         rf_wdat = load_data;
      end
      else begin
         rf_wdat = alu_result;                       // alu reg/imm
      end

      // one write per instr, in its finishing cycle
      rf_we = ((state == st_execute) & (dec.cls.alu_reg | dec.cls.alu_imm | dec.cls.lui |
                                        dec.cls.auipc | dec.cls.jal | dec.cls.jalr))
            | ((state == st_mem) & dec.cls.load & dmem_rdy);
   end

   // --------------------
   // execution fsm
   // --------------------
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         pc    <= rv_core_pkg::pc_reset;
         state <= st_execute;
      end
      else begin
         case (state)
            st_execute : begin
               if (dec.cls.halt) begin
                  state <= st_halt;                  // parked until reset
               end
               else if (is_ls) begin
                  state <= st_mem;                   // request registered now
               end
               else begin
                  pc <= next_pc;
               end
            end
            st_mem : begin
               if (lsu_finish) begin
                  pc    <= pc_inc;
                  state <= st_execute;
               end
            end
            default : state <= st_halt;
         endcase
      end
   end

   assign halted = (state == st_halt);

endmodule

// File: dv/tb_program.svh
// --------------------
// RV32I encoders
// --------------------
function automatic rv_core_pkg::word_t r_type(logic [6:0] f7, int rs2, int rs1,
                                               logic [2:0] f3, int rd);
   return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), 7'b0110011};
endfunction

function automatic rv_core_pkg::word_t i_type(logic [11:0] imm, int rs1, logic [2:0] f3,
                                               int rd, logic [6:0] opc);
   return {imm, 5'(rs1), f3, 5'(rd), opc};   // op-imm, load, jalr
endfunction

function automatic rv_core_pkg::word_t s_type(logic [11:0] imm, int rs2, int rs1,
                                               logic [2:0] f3);
   return {imm[11:5], 5'(rs2), 5'(rs1), f3, imm[4:0], 7'b0100011};
endfunction

function automatic rv_core_pkg::word_t b_type(logic [12:0] imm, int rs2, int rs1,
                                               logic [2:0] f3);
   return {imm[12], imm[10:5], 5'(rs2), 5'(rs1), f3, imm[4:1], imm[11], 7'b1100011};
endfunction

function automatic rv_core_pkg::word_t u_type(logic [19:0] imm, int rd, logic [6:0] opc);
   return {imm, 5'(rd), opc};                // lui, auipc
endfunction

function automatic rv_core_pkg::word_t j_type(logic [20:0] imm, int rd);
   return {imm[20], imm[10:1], imm[11], imm[19:12], 5'(rd), 7'b1101111};
endfunction

// --------------------
// program building
// --------------------
task automatic place(rv_core_pkg::word_t w);
   prog[prog_len] = w;
   prog_len++;
endtask

// sw rs2, addr(x0) plus the write it must produce
task automatic word_store(int rs2, logic [11:0] addr, rv_core_pkg::word_t data);
   rv_core_pkg::dmem_req_t req;
   place(s_type(addr, rs2, 0, 3'b010));
   req = '{strobe: 1'b1, be: 4'hf, addr: 30'(addr >> 2), wdat: data};
   exp_q.push_back(req);
endtask

// sb/sh, lanes and replicated data given explicitly
task automatic lane_store(rv_core_pkg::word_t instr, logic [11:0] addr,
                          rv_core_pkg::byte_en_t be, rv_core_pkg::word_t data);
   rv_core_pkg::dmem_req_t req;
   place(instr);
   req = '{strobe: 1'b1, be: be, addr: 30'(addr >> 2), wdat: data};
   exp_q.push_back(req);
endtask

task automatic load_program();
   rv_core_pkg::word_t wrong_path;
   wrong_path = s_type(12'h1f0, 1, 0, 3'b010);     // sw x1, 0x1f0(x0), never expected
   prog_len   = 0;
   place(u_type(20'h12345, 1, 7'h37));              // lui   x1, 0x12345
   place(i_type(12'h678, 1, 3'b000, 1, 7'h13));     // addi  x1, x1, 0x678
   word_store(1, 12'h100, 32'h1234_5678);
   place(i_type(12'hffb, 0, 3'b000, 2, 7'h13));     // addi  x2, x0, -5
   place(r_type(7'h00, 2, 1, 3'b000, 3));           // add   x3, x1, x2
   word_store(3, 12'h104, 32'h1234_5673);
   place(r_type(7'h20, 2, 0, 3'b000, 4));           // sub   x4, x0, x2
   word_store(4, 12'h108, 32'h0000_0005);
   place(r_type(7'h00, 4, 2, 3'b010, 5));           // slt   x5, x2, x4
   word_store(5, 12'h10c, 32'h0000_0001);
   place(r_type(7'h00, 4, 2, 3'b011, 6));           // sltu  x6, x2, x4
   word_store(6, 12'h110, 32'h0000_0000);
   place(i_type(12'h401, 2, 3'b101, 7, 7'h13));     // srai  x7, x2, 1
   word_store(7, 12'h114, 32'hffff_fffd);
   place(i_type(12'h01c, 2, 3'b101, 8, 7'h13));     // srli  x8, x2, 28
   place(i_type(12'h004, 4, 3'b001, 9, 7'h13));     // slli  x9, x4, 4
   place(r_type(7'h00, 8, 9, 3'b110, 12));          // or    x12, x9, x8
   word_store(12, 12'h118, 32'h0000_005f);
   place(r_type(7'h00, 2, 1, 3'b100, 10));          // xor   x10, x1, x2
   word_store(10, 12'h11c, 32'hedcb_a983);
   place(i_type(12'h0f0, 1, 3'b111, 11, 7'h13));    // andi  x11, x1, 0xf0
   word_store(11, 12'h120, 32'h0000_0070);
   place(u_type(20'h00001, 13, 7'h17));             // auipc x13, 1 sits at 0x58
   word_store(13, 12'h124, 32'h0000_1058);
   lane_store(s_type(12'h131, 1, 0, 3'b000), 12'h131, 4'b0010, 32'h7878_7878);
   lane_store(s_type(12'h136, 1, 0, 3'b001), 12'h136, 4'b1100, 32'h5678_5678);
   // loads of the xor word and the half just stored
   place(i_type(12'h11c, 0, 3'b000, 14, 7'h03));    // lb    x14
   word_store(14, 12'h140, 32'hffff_ff83);
   place(i_type(12'h11d, 0, 3'b100, 15, 7'h03));    // lbu   x15
   word_store(15, 12'h144, 32'h0000_00a9);
   place(i_type(12'h11e, 0, 3'b001, 16, 7'h03));    // lh    x16
   word_store(16, 12'h148, 32'hffff_edcb);
   place(i_type(12'h11c, 0, 3'b101, 17, 7'h03));    // lhu   x17
   word_store(17, 12'h14c, 32'h0000_a983);
   place(i_type(12'h11c, 0, 3'b010, 18, 7'h03));    // lw    x18
   word_store(18, 12'h150, 32'hedcb_a983);
   place(i_type(12'h136, 0, 3'b001, 19, 7'h03));    // lh    x19, upper half
   word_store(19, 12'h154, 32'h0000_5678);
   // branches, taken ones hop over a wrong-path store
   place(b_type(13'd8, 4, 4, 3'b000));              // beq   x4, x4 taken
   place(wrong_path);
   place(b_type(13'd8, 4, 4, 3'b001));              // bne   x4, x4 falls through
   word_store(4, 12'h180, 32'h0000_0005);
   place(b_type(13'd8, 4, 2, 3'b100));              // blt   x2, x4 taken
   place(wrong_path);
   place(b_type(13'd8, 4, 2, 3'b101));              // bge   x2, x4 falls through
   word_store(5, 12'h184, 32'h0000_0001);
   place(b_type(13'd8, 2, 4, 3'b110));              // bltu  x4, x2 taken
   place(wrong_path);
   place(b_type(13'd8, 2, 4, 3'b111));              // bgeu  x4, x2 falls through
   word_store(9, 12'h188, 32'h0000_0050);
   place(j_type(21'd12, 21));                       // jal   x21, +12 from 0xc8
   place(wrong_path);
   place(wrong_path);
   word_store(21, 12'h18c, 32'h0000_00cc);          // link value
   place(i_type(12'd20, 21, 3'b000, 22, 7'h67));    // jalr  x22, 20(x21) to 0xe0
   place(wrong_path);
   word_store(22, 12'h190, 32'h0000_00dc);
   halt_index = prog_len;
   place(32'h0000_0073);                            // ecall, core parks here
   place(wrong_path);
endtask

// File: dv/tb_rv_core.sv
`timescale 1ns/10ps

module tb_rv_core;

   localparam int max_cycles    = 4000;   // ~60 instrs at <= 5 cycles, wide margin
   localparam int settle_cycles = 20;     // watch the parked core a while

   logic                   clk;
   logic                   rst_n;
   rv_core_pkg::pc_t       imem_addr;
   rv_core_pkg::word_t     imem_rdat;
   rv_core_pkg::dmem_req_t dmem_req;
   rv_core_pkg::word_t     dmem_rdat = '0;
   logic                   dmem_rdy  = 1'b0;
   logic                   halted;

   rv_core_pkg::word_t     prog [0:127];
   rv_core_pkg::word_t     dmem [0:255];
   rv_core_pkg::dmem_req_t exp_q [$];     // stores in program order
   int                     prog_len;
   int                     halt_index;
   int                     errors      = 0;
   int                     stores_seen = 0;
   int                     cycles      = 0;
   int                     seed        = 32'hfb39;
   int                     rdy_wait    = 0;
   logic                   load_open   = 1'b0;
   logic                   started;

   `include "tb_program.svh"

   rv_core i_dut (
      .clk       (clk),
      .rst_n     (rst_n),
      .imem_addr (imem_addr),
      .imem_rdat (imem_rdat),
      .dmem_req  (dmem_req),
      .dmem_rdat (dmem_rdat),
      .dmem_rdy  (dmem_rdy),
      .halted    (halted)
   );

   always #50 clk = ~clk;

   task automatic flag_failure(string what);
      errors++;
      $display("%s at %0t ns", what, $time);
   endtask

   task automatic compare_field(string name, rv_core_pkg::word_t got, rv_core_pkg::word_t want);
      assert (got === want) else begin
         errors++;
         $display("Error at %0t ns: %s is 0x%h, expected 0x%h", $time, name, got, want);
      end
   endtask

   // next write against the head of the expected list
   task automatic check_store();
      rv_core_pkg::dmem_req_t want;
      stores_seen++;
      if (exp_q.size() == 0) begin
         flag_failure("store past the end of the expected sequence");
      end
      else begin
         want = exp_q.pop_front();
         compare_field("dmem_req.addr", 32'(dmem_req.addr), 32'(want.addr));
         compare_field("dmem_req.be", 32'(dmem_req.be), 32'(want.be));
         compare_field("dmem_req.wdat", dmem_req.wdat, want.wdat);
      end
   endtask

   function automatic bit lanes_consistent(rv_core_pkg::byte_en_t be, rv_core_pkg::word_t wdat);
      case (be)
         4'b0000, 4'b1111                   : return 1'b1;  // load or word store
         4'b0001, 4'b0010, 4'b0100, 4'b1000 : return wdat == {4{wdat[7:0]}};
         4'b0011, 4'b1100                   : return wdat == {2{wdat[15:0]}};
         default                            : return 1'b0;
      endcase
   endfunction

   // --------------------
   // memory models
   // --------------------
   assign imem_rdat = prog[imem_addr[6:0]];          // async read

   always @(posedge clk) begin
      if (dmem_req.strobe && dmem_req.be != '0) begin
         for (int b = 0; b < 4; b++) begin
            if (dmem_req.be[b]) begin
               dmem[dmem_req.addr[7:0]][8*b +: 8] = dmem_req.wdat[8*b +: 8];
            end
         end
         check_store();
      end
      #1;
      if (dmem_req.strobe && dmem_req.be == '0) begin
         if (!load_open) begin                       // new load, pick its stall
            load_open = 1'b1;
            rdy_wait  = $random(seed) & 3;
         end
         else if (rdy_wait > 0) begin
            rdy_wait--;
         end
         dmem_rdy = (rdy_wait == 0);
      end
      else begin
         load_open = 1'b0;
         dmem_rdy  = 1'b0;
      end
      if (dmem_req.strobe) begin
         dmem_rdat = dmem[dmem_req.addr[7:0]];
      end
   end

   always @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         started <= 1'b0;
      end
      else begin
         started <= 1'b1;                            // first instr done
      end
   end

   always @(posedge clk) begin
      if (rst_n) cycles++;
   end

   // --------------------
   // protocol checks
   // --------------------
   assert property (@(posedge clk)
      !started |-> !dmem_req.strobe && dmem_req.be == '0 && !halted && imem_addr == '0)
      else flag_failure("outputs left their reset values before the first instruction ended");

   // stalled load holds its request, pc frozen
   assert property (@(posedge clk) disable iff (!rst_n)
      dmem_req.strobe && dmem_req.be == '0 && !dmem_rdy
      |=> dmem_req == $past(dmem_req) && imem_addr == $past(imem_addr))
      else flag_failure("load request or pc moved while ready was low");

   assert property (@(posedge clk) disable iff (!rst_n)
      dmem_req.strobe && dmem_req.be != '0 |=> !dmem_req.strobe)
      else flag_failure("store strobe lasted more than one cycle");

   assert property (@(posedge clk) disable iff (!rst_n)
      dmem_req.strobe |-> lanes_consistent(dmem_req.be, dmem_req.wdat))
      else flag_failure("byte enables do not match the replicated write data");

   assert property (@(posedge clk) disable iff (!rst_n)
      halted |=> halted && !dmem_req.strobe && imem_addr == $past(imem_addr))
      else flag_failure("core did not stay parked after halting");

   // --------------------
   // run
   // --------------------
   initial begin
      clk   = 1'b0;
      rst_n = 1'b0;
      for (int i = 0; i < 256; i++) begin
         dmem[i] = {16'(i) ^ 16'hc3a5, 16'(i)};      // index shows in both halves
         if (i < 128) begin
            prog[i] = {25'(i), 7'h7f};              // unknown opcode, halts a runaway
         end
      end
      load_program();
      repeat (16) @(posedge clk);
      #1 rst_n = 1'b1;
      while (!halted && cycles < max_cycles) begin
         @(posedge clk);
      end
      if (!halted) begin
         flag_failure("core did not halt before the cycle limit");
      end
      else begin
         repeat (settle_cycles) @(posedge clk);
         compare_field("imem_addr", 32'(imem_addr), 32'(halt_index));
      end
      if (exp_q.size() != 0) begin
         flag_failure("some expected stores never arrived");
      end
      $display("%0d stores seen, %0d missing, %0d errors", stores_seen, exp_q.size(), errors);
      if (errors == 0) begin
         $display("Test completed successfully");
      end
      else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

// File: filelist.f
+incdir+dv
design/rv_core_pkg.sv
design/rv_decoder.sv
design/rv_regfile.sv
design/rv_alu.sv
design/rv_lsu.sv
design/rv_core.sv
dv/tb_rv_core.sv

// File: Makefile
# Verilator build and run of the rv_core testbench

LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f filelist.f --top-module tb_rv_core -Mdir obj_dir
	./obj_dir/Vtb_rv_core | tee $(LOG)
	@grep -q "Test completed successfully" $(LOG) && echo "PASS" || (echo "FAIL"; exit 1)

clean:
	rm -rf obj_dir $(LOG)
